// File: filelist.f
+incdir+verilog
verilog/dma_desc_pkg.sv
verilog/dma_desc_regs.sv
verilog/dma_desc_fetch.sv
verilog/dma_copy_backend.sv
verilog/dma_mem_arbiter.sv
verilog/dma_desc_wrap.sv
tests/tb_dma_desc_wrap.sv

// File: Bender.yml
package:
  name: dma_desc

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dma_desc_pkg.sv
      - verilog/dma_desc_regs.sv
      - verilog/dma_desc_fetch.sv
      - verilog/dma_copy_backend.sv
      - verilog/dma_mem_arbiter.sv
      - verilog/dma_desc_wrap.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_dma_desc_wrap.sv

// File: tests/tb_dma_desc_wrap.sv
/*
 * Testbench for the descriptor DMA. Random chains are copied and checked against a shadow model.
 * Memory answers every request at once and returns read data one cycle later.
 */
`timescale 1ns/100ps
`include "dma_desc_defs.svh"

module tb_dma_desc_wrap;
  import dma_desc_pkg::*;

  localparam int MAX_DESC = 5;
  localparam int SLOT     = 32; // Words reserved per descriptor region
  localparam logic [`DMA_ADDR_W-1:0] DESC_BASE  = 'h0100;
  localparam logic [`DMA_ADDR_W-1:0] SPARE_DESC = 'h0180;
  localparam logic [`DMA_ADDR_W-1:0] SRC_BASE   = 'h1000;
  localparam logic [`DMA_ADDR_W-1:0] DST_BASE   = 'h8000;
  localparam logic [`DMA_ADDR_W-1:0] SPARE_DST  = 'hc000;

  logic     i_idma_backend;
  logic     rst_n_i;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  logic     irq;

  logic [`DMA_DATA_W-1:0] mem    [0:(1<<`DMA_ADDR_W)-1];
  logic [`DMA_DATA_W-1:0] shadow [0:(1<<`DMA_ADDR_W)-1];
  logic [`DMA_ADDR_W-1:0] d_src  [MAX_DESC];
  logic [`DMA_ADDR_W-1:0] d_dst  [MAX_DESC];
  logic [`DMA_LEN_W-1:0]  d_len  [MAX_DESC];
  int                     n_desc;
  int                     exp_done;
  int                     budget    = 1000; // Margin for reset and register traffic
  int                     cycle_cnt = 0;

  dma_desc_wrap i_dma_desc_wrap (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .reg_req_i      ( reg_req        ),
    .reg_rsp_o      ( reg_rsp        ),
    .mem_req_o      ( mem_req        ),
    .mem_rsp_i      ( mem_rsp        ),
    .irq_o          ( irq            )
  );

  initial begin
    i_idma_backend = 1'b0;
    forever #20 i_idma_backend = ~i_idma_backend;
  end

  // Memory model, gnt stays high
  always @(posedge i_idma_backend) begin
    mem_rsp.rvalid <= 1'b0;
    if (mem_req.req && mem_req.we) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end else if (mem_req.req) begin
      mem_rsp.rvalid <= 1'b1;
      mem_rsp.rdata  <= mem[mem_req.addr];
    end
  end

  always @(posedge i_idma_backend) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > budget) begin
      $display("Timeout: the run went past its limit of %0d cycles", budget);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
    @(posedge i_idma_backend);
    reg_req <= {1'b1, 1'b1, addr, data};
    @(posedge i_idma_backend);
    reg_req <= '0;
  endtask

  task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
    @(posedge i_idma_backend);
    reg_req <= {1'b1, 1'b0, addr, 32'h0};
    @(negedge i_idma_backend);
    data = reg_rsp.rdata;
  endtask

  task automatic store_word(input logic [`DMA_ADDR_W-1:0] a, input logic [31:0] w);
    mem[a]    = w;
    shadow[a] = w;
  endtask

  task automatic build_chain(input int n, input int zero_idx);
    logic [`DMA_ADDR_W-1:0] a;
    int                     words;
    int                     i;
    words = 0;
    for (i = 0; i < n; i++) begin
      d_src[i] = SRC_BASE + i * SLOT + $urandom_range(15);
      d_dst[i] = DST_BASE + i * SLOT + $urandom_range(15);
      d_len[i] = (i == zero_idx) ? 0 : $urandom_range(16, 1);
      a = DESC_BASE + 4 * i;
      store_word(a, d_src[i]);
      store_word(a + 1, d_dst[i]);
      store_word(a + 2, d_len[i]);
      store_word(a + 3, (i == n - 1) ? 0 : a + 4); // Next of zero ends the chain
      words += d_len[i];
    end
    n_desc = n;
    budget += 8 * n + 3 * words;
  endtask

  // Reference copy, in chain order
  task automatic apply_model;
    int i;
    int w;
    for (i = 0; i < n_desc; i++) begin
      for (w = 0; w < d_len[i]; w++) begin
        shadow[d_dst[i] + w] = shadow[d_src[i] + w];
      end
    end
    exp_done += n_desc;
  endtask

  task automatic compare_memory(input logic [`DMA_ADDR_W-1:0] base, input int count);
    logic [`DMA_ADDR_W-1:0] a;
    int                     w;
    for (w = 0; w < count; w++) begin
      a = base + w;
      expect_equal(mem[a], shadow[a], $sformatf("memory word at %h", a));
    end
  endtask

  // Keeps STATUS on the register port so busy is seen in the cycle irq rises
  task automatic wait_irq;
    logic [31:0] status;
    @(posedge i_idma_backend);
    reg_req <= {1'b1, 1'b0, REG_STATUS, 32'h0};
    @(negedge i_idma_backend);
    while (!irq) @(negedge i_idma_backend);
    status = reg_rsp.rdata;
    expect_equal(status[1:0], 2'b10, "STATUS as irq rises");
  endtask

  task automatic poll_busy;
    logic [31:0] status;
    reg_read(REG_STATUS, status);
    expect_equal(status[0], 1'b1, "STATUS busy after start");
    while (status[0]) begin
      expect_equal(irq, 1'b0, "irq_o with interrupt disabled");
      reg_read(REG_STATUS, status);
    end
    expect_equal(status[1:0], 2'b00, "STATUS after chain end");
  endtask

  task automatic finish_chain(input logic use_irq);
    logic [31:0] cnt;
    if (use_irq) begin
      wait_irq();
      reg_write(REG_STATUS, 32'h0);
      @(negedge i_idma_backend);
      expect_equal(irq, 1'b0, "irq_o after STATUS write");
    end else begin
      poll_busy();
    end
    reg_read(REG_DONE_CNT, cnt);
    expect_equal(cnt, exp_done, "done count");
    compare_memory(SRC_BASE, MAX_DESC * SLOT);
    compare_memory(DST_BASE, MAX_DESC * SLOT);
  endtask

  task automatic run_chain(input int n, input int zero_idx, input logic use_irq);
    build_chain(n, zero_idx);
    apply_model();
    reg_write(REG_CTRL, use_irq);
    reg_write(REG_DESC_ADDR, DESC_BASE);
    finish_chain(use_irq);
  endtask

  // A second start while busy must be dropped
  task automatic busy_start;
    logic [31:0] rd;
    build_chain(3, -1);
    apply_model();
    store_word(SPARE_DESC, SRC_BASE);
    store_word(SPARE_DESC + 1, SPARE_DST);
    store_word(SPARE_DESC + 2, 8);
    store_word(SPARE_DESC + 3, 0);
    reg_write(REG_CTRL, 1);
    reg_write(REG_DESC_ADDR, DESC_BASE);
    reg_write(REG_DESC_ADDR, SPARE_DESC);
    reg_read(REG_DESC_ADDR, rd);
    expect_equal(rd, DESC_BASE, "chain address after write while busy");
    finish_chain(1'b1);
    repeat (20) @(posedge i_idma_backend);
    reg_read(REG_STATUS, rd);
    expect_equal(rd[1:0], 2'b00, "STATUS after dropped start");
    reg_read(REG_DONE_CNT, rd);
    expect_equal(rd, exp_done, "done count after dropped start");
    compare_memory(SPARE_DST, SLOT);
  endtask

  initial begin
    void'($urandom(32'hd154619c));
    rst_n_i  = 1'b0;
    reg_req  = '0;
    mem_rsp  = '0;
    mem_rsp.gnt = 1'b1;
    exp_done = 0;
    n_desc   = 0;
    for (int a = 0; a < (1 << `DMA_ADDR_W); a++) begin
      mem[a]    = $urandom;
      shadow[a] = mem[a];
    end
    repeat (10) @(posedge i_idma_backend);
    rst_n_i <= 1'b1;

    run_chain(1, -1, 1'b1);
    repeat (4) run_chain($urandom_range(5, 2), -1, 1'b1);
    run_chain(4, 1, 1'b1);                          // Zero length inside the chain
    run_chain($urandom_range(5, 2), -1, 1'b0);
    busy_start();

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verilog/dma_desc_wrap.sv
/*
 * Descriptor DMA top level. One shared memory master port, one register port.
 * The memory must accept every request and answer reads after one cycle.
 */
`timescale 1ns/100ps
`include "dma_desc_defs.svh"

module dma_desc_wrap (
  input  logic                   i_idma_backend,
  input  logic                   rst_n_i,
  input  dma_desc_pkg::reg_req_t reg_req_i,
  output dma_desc_pkg::reg_rsp_t reg_rsp_o,
  output dma_desc_pkg::mem_req_t mem_req_o,
  input  dma_desc_pkg::mem_rsp_t mem_rsp_i,
  output logic                   irq_o
);
  import dma_desc_pkg::*;

  mem_req_t               fe_req;
  mem_rsp_t               fe_rsp;
  mem_req_t               be_req;
  mem_rsp_t               be_rsp;
  dma_desc_t              desc;
  logic                   desc_valid;
  logic                   desc_take;
  logic                   desc_done;
  logic                   chain_end;
  logic                   fetch_idle;
  logic                   start;
  logic [`DMA_ADDR_W-1:0] chain_addr;

  dma_desc_regs i_dma_desc_regs (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .reg_req_i      ( reg_req_i      ),
    .reg_rsp_o      ( reg_rsp_o      ),
    .start_o        ( start          ),
    .chain_addr_o   ( chain_addr     ),
    .desc_done_i    ( desc_done      ),
    .chain_end_i    ( chain_end      ),
    .fetch_idle_i   ( fetch_idle     ),
    .irq_o          ( irq_o          )
  );

  dma_desc_fetch i_dma_desc_fetch (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .start_i        ( start          ),
    .chain_addr_i   ( chain_addr     ),
    .mem_req_o      ( fe_req         ),
    .mem_rsp_i      ( fe_rsp         ),
    .desc_o         ( desc           ),
    .desc_valid_o   ( desc_valid     ),
    .desc_take_i    ( desc_take      ),
    .chain_end_o    ( chain_end      ),
    .fetch_idle_o   ( fetch_idle     )
  );

  dma_copy_backend i_dma_copy_backend (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .desc_i         ( desc           ),
    .desc_valid_i   ( desc_valid     ),
    .desc_take_o    ( desc_take      ),
    .mem_req_o      ( be_req         ),
    .mem_rsp_i      ( be_rsp         ),
    .desc_done_o    ( desc_done      )
  );

  dma_mem_arbiter i_dma_mem_arbiter (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .fe_req_i       ( fe_req         ),
    .fe_rsp_o       ( fe_rsp         ),
    .be_req_i       ( be_req         ),
    .be_rsp_o       ( be_rsp         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_rsp_i      ( mem_rsp_i      )
  );

endmodule

// File: verilog/dma_mem_arbiter.sv
/*
 * Fixed-priority arbiter for the memory port, backend first.
 * Assumes read data returns exactly one cycle after a granted read.
 */
`timescale 1ns/100ps

module dma_mem_arbiter (
  input  logic                   i_idma_backend,
  input  logic                   rst_n_i,
  input  dma_desc_pkg::mem_req_t fe_req_i,
  output dma_desc_pkg::mem_rsp_t fe_rsp_o,
  input  dma_desc_pkg::mem_req_t be_req_i,
  output dma_desc_pkg::mem_rsp_t be_rsp_o,
  output dma_desc_pkg::mem_req_t mem_req_o,
  input  dma_desc_pkg::mem_rsp_t mem_rsp_i
);

  logic rd_pend_q;
  logic rd_owner_be_q; // Owner of the read in flight

  assign mem_req_o = be_req_i.req ? be_req_i : fe_req_i;

  assign be_rsp_o.gnt = mem_rsp_i.gnt & be_req_i.req;
  assign fe_rsp_o.gnt = mem_rsp_i.gnt & fe_req_i.req & !be_req_i.req;

  assign be_rsp_o.rvalid = mem_rsp_i.rvalid & rd_pend_q & rd_owner_be_q;
  assign fe_rsp_o.rvalid = mem_rsp_i.rvalid & rd_pend_q & !rd_owner_be_q;
  assign be_rsp_o.rdata  = mem_rsp_i.rdata;
  assign fe_rsp_o.rdata  = mem_rsp_i.rdata;

  always_ff @(posedge i_idma_backend) begin
    if (!rst_n_i) begin
      rd_pend_q     <= 1'b0;
      rd_owner_be_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_req_o.req & !mem_req_o.we & mem_rsp_i.gnt;
      if (mem_req_o.req && !mem_req_o.we && mem_rsp_i.gnt) begin
        rd_owner_be_q <= be_req_i.req;
      end
    end
  end

  // Read data goes back only to the master whose read was granted
  a_rvalid_one_owner: assert property (@(posedge i_idma_backend) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> (be_rsp_o.rvalid == $past(be_rsp_o.gnt && !be_req_i.we)) &&
                         (fe_rsp_o.rvalid == $past(fe_rsp_o.gnt && !fe_req_i.we)));

  // Every memory response belongs to a read granted here
  a_rvalid_routed: assert property (@(posedge i_idma_backend) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> fe_rsp_o.rvalid || be_rsp_o.rvalid);

endmodule

// File: verilog/dma_copy_backend.sv
/*
 * Copy backend, one word at a time, read then write.
 * Zero-length descriptors complete without memory traffic.
 */
`timescale 1ns/100ps
`include "dma_desc_defs.svh"

module dma_copy_backend (
  input  logic                    i_idma_backend,
  input  logic                    rst_n_i,
  input  dma_desc_pkg::dma_desc_t desc_i,
  input  logic                    desc_valid_i,
  output logic                    desc_take_o,
  output dma_desc_pkg::mem_req_t  mem_req_o,
  input  dma_desc_pkg::mem_rsp_t  mem_rsp_i,
  output logic                    desc_done_o
);
  import dma_desc_pkg::*;

  copy_state_e            state_q;
  logic [`DMA_ADDR_W-1:0] src_q;
  logic [`DMA_ADDR_W-1:0] dst_q;
  logic [`DMA_LEN_W-1:0]  left_q;
  logic [`DMA_DATA_W-1:0] data_q;
  logic [`DMA_DATA_W-1:0] wdata;
  logic                   done_q;
  logic                   take;
  logic                   wr_gnt;

  assign take   = (state_q == COPY_IDLE) && desc_valid_i;
  assign wr_gnt = (state_q == COPY_WRITE) && mem_rsp_i.gnt;
  assign wdata  = mem_rsp_i.rvalid ? mem_rsp_i.rdata : data_q; // Forward fresh read data

  always_comb begin
    mem_req_o       = '0;
    mem_req_o.req   = (state_q != COPY_IDLE);
    mem_req_o.we    = (state_q == COPY_WRITE);
    mem_req_o.addr  = (state_q == COPY_WRITE) ? dst_q : src_q;
    mem_req_o.wdata = wdata;
  end

  always_ff @(posedge i_idma_backend) begin
    if (!rst_n_i) begin
      state_q <= COPY_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        COPY_IDLE: begin
          if (take) begin
            if (desc_i.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= COPY_READ;
            end
          end
        end
        COPY_READ: begin
          if (mem_rsp_i.gnt) begin
            state_q <= COPY_WRITE;
          end
        end
        default: begin
          if (mem_rsp_i.gnt) begin
            if (left_q == 1) begin
              done_q  <= 1'b1;
              state_q <= COPY_IDLE;
            end else begin
              state_q <= COPY_READ;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (take) begin
      src_q  <= desc_i.src;
      dst_q  <= desc_i.dst;
      left_q <= desc_i.len;
    end else if (wr_gnt) begin
      src_q  <= src_q + 1'b1;
      dst_q  <= dst_q + 1'b1;
      left_q <= left_q - 1'b1;
    end
    if (mem_rsp_i.rvalid) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

  assign desc_take_o = take;
  assign desc_done_o = done_q;

  // A request only starts right after a descriptor has been taken
  a_no_req_idle: assert property (@(posedge i_idma_backend) disable iff (!rst_n_i)
    $rose(mem_req_o.req) |-> $past(desc_take_o));

  // Read data routed here only ever lands while the write is pending
  a_rdata_in_write: assert property (@(posedge i_idma_backend) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> state_q == COPY_WRITE);

endmodule

// File: verilog/dma_desc_fetch.sv
/*
 * Descriptor fetch frontend with a one-entry buffer toward the backend.
 * Reads four words per descriptor at consecutive addresses, then follows next.
 * start_i is only honoured while idle.
 */
`timescale 1ns/100ps
`include "dma_desc_defs.svh"

module dma_desc_fetch (
  input  logic                    i_idma_backend,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  logic [`DMA_ADDR_W-1:0]  chain_addr_i,
  output dma_desc_pkg::mem_req_t  mem_req_o,
  input  dma_desc_pkg::mem_rsp_t  mem_rsp_i,
  output dma_desc_pkg::dma_desc_t desc_o,
  output logic                    desc_valid_o,
  input  logic                    desc_take_i,
  output logic                    chain_end_o,
  output logic                    fetch_idle_o
);
  import dma_desc_pkg::*;

  fetch_state_e           state_q;
  logic [2:0]             issue_cnt_q; // Reads granted, 0 to 4
  logic [1:0]             ret_cnt_q;   // Words returned
  logic [`DMA_ADDR_W-1:0] base_q;
  dma_desc_t              stage_q;
  dma_desc_t              fetched;
  dma_desc_t              desc_q;
  logic                   desc_valid_q;
  logic                   chain_end_q;
  logic                   last_word;
  logic                   desc_ready;
  logic                   buf_free;
  logic                   push;

  assign last_word  = (state_q == FETCH_READ) && mem_rsp_i.rvalid && (ret_cnt_q == 2'd3);
  assign desc_ready = last_word || (state_q == FETCH_WAIT_BUF);
  assign buf_free   = !desc_valid_q || desc_take_i;
  assign push       = desc_ready && buf_free;

  // Next pointer bypasses the staging register on the last word
  always_comb begin
    fetched = stage_q;
    if (last_word) begin
      fetched.next = mem_rsp_i.rdata[`DMA_ADDR_W-1:0];
    end
  end

  always_comb begin
    mem_req_o      = '0;
    mem_req_o.req  = (state_q == FETCH_READ) && !issue_cnt_q[2];
    mem_req_o.addr = base_q + {{(`DMA_ADDR_W-2){1'b0}}, issue_cnt_q[1:0]};
  end

  always_ff @(posedge i_idma_backend) begin
    if (!rst_n_i) begin
      state_q      <= FETCH_IDLE;
      issue_cnt_q  <= '0;
      ret_cnt_q    <= '0;
      desc_valid_q <= 1'b0;
      chain_end_q  <= 1'b0;
    end else begin
      if (desc_take_i) begin
        desc_valid_q <= 1'b0;
      end
      if (mem_req_o.req && mem_rsp_i.gnt) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end
      if (mem_rsp_i.rvalid) begin
        ret_cnt_q <= ret_cnt_q + 1'b1; // Wraps to zero after the fourth word
      end
      case (state_q)
        FETCH_IDLE: begin
          if (start_i) begin
            state_q     <= FETCH_READ;
            issue_cnt_q <= '0;
            ret_cnt_q   <= '0;
            chain_end_q <= 1'b0;
          end
        end
        FETCH_READ: begin
          if (last_word && !buf_free) begin
            state_q <= FETCH_WAIT_BUF;
          end
        end
        default: ;
      endcase
      if (push) begin
        desc_valid_q <= 1'b1;
        issue_cnt_q  <= '0;
        ret_cnt_q    <= '0;
        if (fetched.next == '0) begin
          chain_end_q <= 1'b1;
          state_q     <= FETCH_IDLE;
        end else begin
          state_q <= FETCH_READ;
        end
      end
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (state_q == FETCH_IDLE && start_i) begin
      base_q <= chain_addr_i;
    end else if (push && fetched.next != '0) begin
      base_q <= fetched.next;
    end
    if (mem_rsp_i.rvalid) begin
      case (ret_cnt_q)
        2'd0:    stage_q.src  <= mem_rsp_i.rdata[`DMA_ADDR_W-1:0];
        2'd1:    stage_q.dst  <= mem_rsp_i.rdata[`DMA_ADDR_W-1:0];
        2'd2:    stage_q.len  <= mem_rsp_i.rdata[`DMA_LEN_W-1:0];
        default: stage_q.next <= mem_rsp_i.rdata[`DMA_ADDR_W-1:0];
      endcase
    end
    if (push) begin
      desc_q <= fetched;
    end
  end

  assign desc_o       = desc_q;
  assign desc_valid_o = desc_valid_q;
  assign chain_end_o  = chain_end_q;
  assign fetch_idle_o = (state_q == FETCH_IDLE) && !desc_valid_q;

  // An offered descriptor stays put until the backend takes it
  a_desc_hold: assert property (@(posedge i_idma_backend) disable iff (!rst_n_i)
    desc_valid_o && !desc_take_i |=> desc_valid_o && $stable(desc_o));

endmodule

// File: verilog/dma_desc_regs.sv
/*
 * Register block. A DESC_ADDR write while busy is dropped.
 * Any STATUS write clears irq. The done count only wraps, it is never cleared.
 */
`timescale 1ns/100ps
`include "dma_desc_defs.svh"

module dma_desc_regs (
  input  logic                   i_idma_backend,
  input  logic                   rst_n_i,
  input  dma_desc_pkg::reg_req_t reg_req_i,
  output dma_desc_pkg::reg_rsp_t reg_rsp_o,
  output logic                   start_o,
  output logic [`DMA_ADDR_W-1:0] chain_addr_o,
  input  logic                   desc_done_i,
  input  logic                   chain_end_i,
  input  logic                   fetch_idle_i,
  output logic                   irq_o
);
  import dma_desc_pkg::*;

  reg_addr_e              reg_addr;
  logic                   wr_en;
  logic                   chain_done;
  logic                   irq_en_q;
  logic                   busy_q;
  logic                   irq_q;
  logic                   start_q;
  logic [`DMA_ADDR_W-1:0] chain_addr_q;
  logic [`DMA_DATA_W-1:0] done_cnt_q;

  assign reg_addr   = reg_addr_e'(reg_req_i.addr);
  assign wr_en      = reg_req_i.valid & reg_req_i.write;
  assign chain_done = desc_done_i & chain_end_i & fetch_idle_i; // Last descriptor retired

  always_ff @(posedge i_idma_backend) begin
    if (!rst_n_i) begin
      irq_en_q     <= 1'b0;
      busy_q       <= 1'b0;
      irq_q        <= 1'b0;
      start_q      <= 1'b0;
      chain_addr_q <= '0;
      done_cnt_q   <= '0;
    end else begin
      start_q <= 1'b0;
      if (desc_done_i) begin
        done_cnt_q <= done_cnt_q + 1'b1;
      end
      if (wr_en && reg_addr == REG_CTRL) begin
        irq_en_q <= reg_req_i.wdata[0];
      end
      if (wr_en && reg_addr == REG_STATUS) begin
        irq_q <= 1'b0;
      end
      if (wr_en && reg_addr == REG_DESC_ADDR && !busy_q) begin
        chain_addr_q <= reg_req_i.wdata[`DMA_ADDR_W-1:0];
        start_q      <= 1'b1;
        busy_q       <= 1'b1;
      end
      if (chain_done && busy_q) begin
        busy_q <= 1'b0;
        if (irq_en_q) begin
          irq_q <= 1'b1; // Wins over a STATUS write in the same cycle
        end
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_addr)
      REG_DESC_ADDR: reg_rsp_o.rdata[`DMA_ADDR_W-1:0] = chain_addr_q;
      REG_CTRL:      reg_rsp_o.rdata[0] = irq_en_q;
      REG_STATUS:    reg_rsp_o.rdata[1:0] = {irq_q, busy_q};
      default:       reg_rsp_o.rdata = done_cnt_q;
    endcase
  end

  assign start_o      = start_q;
  assign chain_addr_o = chain_addr_q;
  assign irq_o        = irq_q;

endmodule

// File: verilog/dma_desc_pkg.sv
/*
 * Types shared by the descriptor DMA blocks.
 * A descriptor is four words in memory: src, dst, len, next. A next of zero ends the chain.
 */
`include "dma_desc_defs.svh"

package dma_desc_pkg;

  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] src;
    logic [`DMA_ADDR_W-1:0] dst;
    logic [`DMA_LEN_W-1:0]  len;
    logic [`DMA_ADDR_W-1:0] next;
  } dma_desc_t;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`DMA_ADDR_W-1:0] addr;
    logic [`DMA_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   rvalid; // One cycle after a granted read
    logic [`DMA_DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [`DMA_REG_ADDR_W-1:0] addr;
    logic [`DMA_DATA_W-1:0]     wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`DMA_DATA_W-1:0] rdata;
  } reg_rsp_t;

  typedef enum logic [`DMA_REG_ADDR_W-1:0] {
    REG_DESC_ADDR = 2'd0,
    REG_CTRL      = 2'd1, // Bit 0 is interrupt enable
    REG_STATUS    = 2'd2, // Bit 0 busy, bit 1 irq
    REG_DONE_CNT  = 2'd3
  } reg_addr_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_READ,
    FETCH_WAIT_BUF
  } fetch_state_e;

  typedef enum logic [1:0] {
    COPY_IDLE,
    COPY_READ,
    COPY_WRITE
  } copy_state_e;

endpackage

// File: verilog/dma_desc_defs.svh
/*
 * Widths for the descriptor DMA. Memory and register ports are word addressed.
 * Descriptor fields are taken from the low bits of each 32-bit word.
 */
`ifndef DMA_DESC_DEFS_SVH
`define DMA_DESC_DEFS_SVH

// Memory word address width
`define DMA_ADDR_W 16

// Memory and register data width
`define DMA_DATA_W 32

// Transfer length in words
`define DMA_LEN_W 16

// Register offset width, four registers
`define DMA_REG_ADDR_W 2

`endif
